/* verilog/cpuPkg.sv */
`default_nettype none

package cpuPkg;

    localparam int XLEN = 32;
    localparam int RAM_WORDS = 64;
    localparam int RAM_AW = $clog2(RAM_WORDS);

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      regIdx_t;
    typedef logic [3:0]      aluOp_t;
    typedef logic [2:0]      immSel_t;

    // major opcodes of the supported subset
    localparam logic [6:0] OP_R      = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_LUI    = 7'b0110111;

    localparam aluOp_t ALU_ADD   = 4'd0;
    localparam aluOp_t ALU_SUB   = 4'd1;
    localparam aluOp_t ALU_AND   = 4'd2;
    localparam aluOp_t ALU_OR    = 4'd3;
    localparam aluOp_t ALU_XOR   = 4'd4;
    localparam aluOp_t ALU_SLT   = 4'd5;
    localparam aluOp_t ALU_SLL   = 4'd6;
    localparam aluOp_t ALU_SRL   = 4'd7;
    localparam aluOp_t ALU_PASSB = 4'd8;

    localparam immSel_t IMM_I = 3'd0;
    localparam immSel_t IMM_S = 3'd1;
    localparam immSel_t IMM_B = 3'd2;
    localparam immSel_t IMM_J = 3'd3;
    localparam immSel_t IMM_U = 3'd4;

    // write-back source select
    localparam logic [1:0] RES_ALU = 2'd0;
    localparam logic [1:0] RES_MEM = 2'd1;
    localparam logic [1:0] RES_PC4 = 2'd2;

    typedef struct packed {
        logic [6:0] funct7;
        regIdx_t    rs2;
        regIdx_t    rs1;
        logic [2:0] funct3;
        regIdx_t    rd;
        logic [6:0] opcode;
    } rFmt_t;

    typedef struct packed {
        logic [11:0] imm11_0;
        logic [19:0] rest;
    } iFmt_t;

    typedef struct packed {
        logic [6:0]  imm11_5;
        logic [12:0] regs;
        logic [4:0]  imm4_0;
        logic [6:0]  opcode;
    } sFmt_t;

    typedef struct packed {
        logic        imm12;
        logic [5:0]  imm10_5;
        logic [12:0] regs;
        logic [3:0]  imm4_1;
        logic        imm11;
        logic [6:0]  opcode;
    } bFmt_t;

    typedef struct packed {
        logic        imm20;
        logic [9:0]  imm10_1;
        logic        imm11;
        logic [7:0]  imm19_12;
        logic [11:0] rest;
    } jFmt_t;

    typedef struct packed {
        logic [19:0] imm31_12;
        logic [11:0] rest;
    } uFmt_t;

    // one instruction word seen through each encoding
    typedef union packed {
        rFmt_t r;
        iFmt_t i;
        sFmt_t s;
        bFmt_t b;
        jFmt_t j;
        uFmt_t u;
    } instr_u;

endpackage

`default_nettype wire

/* verilog/pcUnit.sv */
`default_nettype none

module pcUnit (
    input  logic          clk,
    input  logic          rstN_i,
    input  cpuPkg::word_t immExt_i,
    input  logic          branchTaken_i,
    input  logic          jump_i,
    output cpuPkg::word_t pc_o,
    output cpuPkg::word_t pcPlus4_o
);
    import cpuPkg::*;

    word_t pcTarget;
    word_t nextPc;

    assign pcPlus4_o = pc_o + 32'd4;
    // branch and jal targets are both pc relative
    assign pcTarget = pc_o + immExt_i;
    assign nextPc = (branchTaken_i || jump_i) ? pcTarget : pcPlus4_o;

    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            pc_o <= '0;
        end else begin
            pc_o <= nextPc;
        end
    end

endmodule

`default_nettype wire

/* verilog/controlDecoder.sv */
`default_nettype none

module controlDecoder (
    input  cpuPkg::instr_u  instr_i,
    output logic            regWe_o,
    output logic            memWe_o,
    output logic            aluSrc_o,
    output logic            branch_o,
    output logic            jump_o,
    output cpuPkg::aluOp_t  aluOp_o,
    output cpuPkg::immSel_t immSel_o,
    output logic [1:0]      resultSel_o
);
    import cpuPkg::*;

    always_comb begin
        // unknown opcodes fall through to a no-op
        regWe_o     = 1'b0;
        memWe_o     = 1'b0;
        aluSrc_o    = 1'b0;
        branch_o    = 1'b0;
        jump_o      = 1'b0;
        aluOp_o     = ALU_ADD;
        immSel_o    = IMM_I;
        resultSel_o = RES_ALU;

        case (instr_i.r.opcode)
            OP_R: begin
                regWe_o = 1'b1;
                case (instr_i.r.funct3)
                    3'b000: aluOp_o = instr_i.r.funct7[5] ? ALU_SUB : ALU_ADD;
                    3'b001: aluOp_o = ALU_SLL;
                    3'b010: aluOp_o = ALU_SLT;
                    3'b100: aluOp_o = ALU_XOR;
                    3'b101: begin
                        aluOp_o = ALU_SRL;
                        // sra has funct7[5] set, not implemented
                        regWe_o = !instr_i.r.funct7[5];
                    end
                    3'b110: aluOp_o = ALU_OR;
                    3'b111: aluOp_o = ALU_AND;
                    default: regWe_o = 1'b0;
                endcase
            end
            OP_IMM: begin
                regWe_o  = 1'b1;
                aluSrc_o = 1'b1;
                case (instr_i.r.funct3)
                    3'b000: aluOp_o = ALU_ADD;
                    3'b010: aluOp_o = ALU_SLT;
                    3'b100: aluOp_o = ALU_XOR;
                    3'b110: aluOp_o = ALU_OR;
                    3'b111: aluOp_o = ALU_AND;
                    default: regWe_o = 1'b0;
                endcase
            end
            OP_LOAD: begin
                // word loads only
                regWe_o     = (instr_i.r.funct3 == 3'b010);
                aluSrc_o    = 1'b1;
                resultSel_o = RES_MEM;
            end
            OP_STORE: begin
                memWe_o  = (instr_i.r.funct3 == 3'b010);
                aluSrc_o = 1'b1;
                immSel_o = IMM_S;
            end
            OP_BRANCH: begin
                // condition itself is resolved in the alu
                branch_o = 1'b1;
                aluOp_o  = ALU_SUB;
                immSel_o = IMM_B;
            end
            OP_JAL: begin
                regWe_o     = 1'b1;
                jump_o      = 1'b1;
                immSel_o    = IMM_J;
                resultSel_o = RES_PC4;
            end
            OP_LUI: begin
                regWe_o  = 1'b1;
                aluSrc_o = 1'b1;
                aluOp_o  = ALU_PASSB;
                immSel_o = IMM_U;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* verilog/regFile.sv */
`default_nettype none

module regFile (
    input  logic            clk,
    input  logic            rstN_i,
    input  cpuPkg::regIdx_t rs1Addr_i,
    input  cpuPkg::regIdx_t rs2Addr_i,
    input  cpuPkg::regIdx_t rdAddr_i,
    input  logic            we_i,
    input  cpuPkg::word_t   wd_i,
    output cpuPkg::word_t   rs1Data_o,
    output cpuPkg::word_t   rs2Data_o
);
    import cpuPkg::*;

    // x0 has no storage
    word_t regs [1:31];

    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            for (int k = 1; k < 32; k++) begin
                regs[k] <= '0;
            end
        end else if (we_i && (rdAddr_i != '0)) begin
            regs[rdAddr_i] <= wd_i;
        end
    end

    assign rs1Data_o = (rs1Addr_i == '0) ? '0 : regs[rs1Addr_i];
    assign rs2Data_o = (rs2Addr_i == '0) ? '0 : regs[rs2Addr_i];

endmodule

`default_nettype wire

/* verilog/immExtend.sv */
`default_nettype none

module immExtend (
    input  cpuPkg::instr_u  instr_i,
    input  cpuPkg::immSel_t immSel_i,
    output cpuPkg::word_t   immExt_o
);
    import cpuPkg::*;

    always_comb begin
        case (immSel_i)
            IMM_I: immExt_o = {{20{instr_i.i.imm11_0[11]}}, instr_i.i.imm11_0};
            IMM_S: immExt_o = {{20{instr_i.s.imm11_5[6]}}, instr_i.s.imm11_5,
                               instr_i.s.imm4_0};
            // branch offsets are in halfwords, bit 0 always zero
            IMM_B: immExt_o = {{19{instr_i.b.imm12}}, instr_i.b.imm12,
                               instr_i.b.imm11, instr_i.b.imm10_5,
                               instr_i.b.imm4_1, 1'b0};
            IMM_J: immExt_o = {{11{instr_i.j.imm20}}, instr_i.j.imm20,
                               instr_i.j.imm19_12, instr_i.j.imm11,
                               instr_i.j.imm10_1, 1'b0};
            IMM_U: immExt_o = {instr_i.u.imm31_12, 12'b0};
            default: immExt_o = '0;
        endcase
    end

endmodule

`default_nettype wire

/* verilog/alu.sv */
`default_nettype none

module alu (
    input  cpuPkg::word_t  srcA_i,
    input  cpuPkg::word_t  srcB_i,
    input  cpuPkg::aluOp_t aluOp_i,
    input  logic [2:0]     branchCond_i,
    input  logic           branchEn_i,
    output cpuPkg::word_t  result_o,
    output logic           branchTaken_o
);
    import cpuPkg::*;

    word_t diff;
    logic  isZero;
    logic  lessThan;

    assign diff = srcA_i - srcB_i;
    assign isZero = (diff == '0);
    // signed less-than from the sign of the difference, corrected for overflow
    assign lessThan = diff[XLEN-1] ^
                      ((srcA_i[XLEN-1] ^ srcB_i[XLEN-1]) & (diff[XLEN-1] ^ srcA_i[XLEN-1]));

    always_comb begin
        case (aluOp_i)
            ALU_ADD:   result_o = srcA_i + srcB_i;
            ALU_SUB:   result_o = diff;
            ALU_AND:   result_o = srcA_i & srcB_i;
            ALU_OR:    result_o = srcA_i | srcB_i;
            ALU_XOR:   result_o = srcA_i ^ srcB_i;
            ALU_SLT:   result_o = {{(XLEN-1){1'b0}}, lessThan};
            ALU_SLL:   result_o = srcA_i << srcB_i[4:0];
            ALU_SRL:   result_o = srcA_i >> srcB_i[4:0];
            ALU_PASSB: result_o = srcB_i;
            default:   result_o = '0;
        endcase
    end

    always_comb begin
        branchTaken_o = 1'b0;
        if (branchEn_i) begin
            case (branchCond_i)
                3'b000: branchTaken_o = isZero;
                3'b001: branchTaken_o = !isZero;
                3'b100: branchTaken_o = lessThan;
                default: branchTaken_o = 1'b0;
            endcase
        end
    end

endmodule

`default_nettype wire

/* verilog/dataRam.sv */
`default_nettype none

module dataRam (
    input  logic          clk,
    input  logic          we_i,
    input  cpuPkg::word_t addr_i,
    input  cpuPkg::word_t wd_i,
    output cpuPkg::word_t rd_o
);
    import cpuPkg::*;

    logic [RAM_AW-1:0] wordIdx;

    // starts out cleared
    word_t mem [RAM_WORDS] = '{default: '0};

    // byte address to word index, upper bits wrap
    assign wordIdx = addr_i[RAM_AW+1:2];

    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[wordIdx] <= wd_i;
        end
    end

    assign rd_o = mem[wordIdx];

endmodule

`default_nettype wire

/* verilog/cpuTop.sv */
`default_nettype none

module cpuTop (
    input  logic            clk,
    input  logic            rstN_i,
    input  cpuPkg::word_t   instr_i,
    output cpuPkg::word_t   pcAddr_o,
    output logic            regWe_o,
    output cpuPkg::regIdx_t regAddr_o,
    output cpuPkg::word_t   regData_o
);
    import cpuPkg::*;

    instr_u     instr;
    word_t      pcPlus4;
    logic       regWe;
    logic       memWe;
    logic       aluSrc;
    logic       branch;
    logic       jump;
    aluOp_t     aluOp;
    immSel_t    immSel;
    logic [1:0] resultSel;
    word_t      rs1Data;
    word_t      rs2Data;
    word_t      immExt;
    word_t      aluSrcB;
    word_t      aluResult;
    logic       branchTaken;
    word_t      ramData;
    word_t      wbData;

    assign instr = instr_i;

    pcUnit pcUnit (
        .clk(clk),
        .rstN_i(rstN_i),
        .immExt_i(immExt),
        .branchTaken_i(branchTaken),
        .jump_i(jump),
        .pc_o(pcAddr_o),
        .pcPlus4_o(pcPlus4)
    );

    controlDecoder controlDecoder (
        .instr_i(instr),
        .regWe_o(regWe),
        .memWe_o(memWe),
        .aluSrc_o(aluSrc),
        .branch_o(branch),
        .jump_o(jump),
        .aluOp_o(aluOp),
        .immSel_o(immSel),
        .resultSel_o(resultSel)
    );

    regFile regFile (
        .clk(clk),
        .rstN_i(rstN_i),
        .rs1Addr_i(instr.r.rs1),
        .rs2Addr_i(instr.r.rs2),
        .rdAddr_i(instr.r.rd),
        .we_i(regWe),
        .wd_i(wbData),
        .rs1Data_o(rs1Data),
        .rs2Data_o(rs2Data)
    );

    immExtend immExtend (
        .instr_i(instr),
        .immSel_i(immSel),
        .immExt_o(immExt)
    );

    // second operand is register or immediate
    assign aluSrcB = aluSrc ? immExt : rs2Data;

    alu alu (
        .srcA_i(rs1Data),
        .srcB_i(aluSrcB),
        .aluOp_i(aluOp),
        .branchCond_i(instr.r.funct3),
        .branchEn_i(branch),
        .result_o(aluResult),
        .branchTaken_o(branchTaken)
    );

    dataRam dataRam (
        .clk(clk),
        .we_i(memWe),
        .addr_i(aluResult),
        .wd_i(rs2Data),
        .rd_o(ramData)
    );

    always_comb begin
        case (resultSel)
            RES_MEM: wbData = ramData;
            RES_PC4: wbData = pcPlus4;
            default: wbData = aluResult;
        endcase
    end

    // write-back port for the environment
    assign regWe_o   = regWe;
    assign regAddr_o = instr.r.rd;
    assign regData_o = wbData;

endmodule

`default_nettype wire

/* tb/cpuTop_assert.sv */
`default_nettype none

module cpuTop_assert (
    input logic          clk,
    input logic          rstN_i,
    input cpuPkg::word_t pcAddr_i,
    input logic          regWe_i,
    input cpuPkg::word_t regData_i
);

    // fetch is always a whole word
    pcAligned: assert property (@(posedge clk) disable iff (!rstN_i) pcAddr_i[1:0] == 2'b00)
        else $error("pcAddr_o is not word aligned");

    pcStartsAtZero: assert property (@(posedge clk) $rose(rstN_i) |-> pcAddr_i == '0)
        else $error("pcAddr_o is not zero after reset release");

    wbDataKnown: assert property (@(posedge clk) disable iff (!rstN_i)
                                  regWe_i |-> !$isunknown(regData_i))
        else $error("regData_o has unknown bits during a register write");

endmodule

bind cpuTop cpuTop_assert cpuChecks (
    .clk(clk),
    .rstN_i(rstN_i),
    .pcAddr_i(pcAddr_o),
    .regWe_i(regWe_o),
    .regData_i(regData_o)
);

`default_nettype wire

/* tb/cpuTop_tb.sv */
`default_nettype none

module cpuTop_tb;
    import cpuPkg::*;

    logic    clk;
    logic    rstN;
    word_t   instr;
    word_t   pcAddr;
    logic    regWe;
    regIdx_t regAddr;
    word_t   regData;

    // instruction table, one row per executed instruction
    word_t   instrQ [$];
    word_t   pcQ [$];
    logic    weQ [$];
    regIdx_t rdQ [$];
    word_t   dataQ [$];

    int wordErrors = 0;
    int idxErrors = 0;
    int bitErrors = 0;
    int timeoutErrors = 0;
    int cycleLimit = 0;
    int cycles = 0;
    int randomSteps = 40;

    cpuTop uut (
        .clk(clk),
        .rstN_i(rstN),
        .instr_i(instr),
        .pcAddr_o(pcAddr),
        .regWe_o(regWe),
        .regAddr_o(regAddr),
        .regData_o(regData)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // small assembler for the table
    function automatic word_t encR(int f7, int rs2, int rs1, int f3, int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OP_R};
    endfunction

    function automatic word_t encI(int imm, int rs1, int f3, int rd, logic [6:0] op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
    endfunction

    function automatic word_t encS(int imm, int rs2, int rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], OP_STORE};
    endfunction

    function automatic word_t encB(int imm, int rs2, int rs1, int f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], OP_BRANCH};
    endfunction

    function automatic word_t encJ(int imm, int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], OP_JAL};
    endfunction

    function automatic word_t encU(int imm, int rd);
        return {imm[19:0], rd[4:0], OP_LUI};
    endfunction

    function automatic word_t xorshift(word_t s);
        word_t x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic addRow(word_t ins, int pc, logic we, int rd, word_t data);
        instrQ.push_back(ins);
        pcQ.push_back(pc);
        weQ.push_back(we);
        rdQ.push_back(rd[4:0]);
        dataQ.push_back(data);
    endtask

    task automatic buildTable();
        addRow(encI(5, 0, 0, 1, OP_IMM), 0, 1'b1, 1, 32'd5);
        addRow(encI(-3, 0, 0, 2, OP_IMM), 4, 1'b1, 2, 32'hFFFF_FFFD);
        addRow(encR(0, 2, 1, 0, 3), 8, 1'b1, 3, 32'd2);
        addRow(encR(32, 2, 1, 0, 4), 12, 1'b1, 4, 32'd8);
        addRow(encR(0, 2, 1, 7, 6), 16, 1'b1, 6, 32'd5);
        addRow(encR(0, 2, 1, 6, 7), 20, 1'b1, 7, 32'hFFFF_FFFD);
        addRow(encR(0, 2, 1, 4, 8), 24, 1'b1, 8, 32'hFFFF_FFF8);
        addRow(encR(0, 1, 2, 2, 9), 28, 1'b1, 9, 32'd1);
        addRow(encR(0, 1, 1, 1, 10), 32, 1'b1, 10, 32'h0000_00A0);
        addRow(encR(0, 1, 2, 5, 11), 36, 1'b1, 11, 32'h07FF_FFFF);
        addRow(encU('h12345, 12), 40, 1'b1, 12, 32'h1234_5000);
        addRow(encI('h678, 12, 6, 13, OP_IMM), 44, 1'b1, 13, 32'h1234_5678);
        addRow(encI('hF0, 13, 7, 14, OP_IMM), 48, 1'b1, 14, 32'h0000_0070);
        addRow(encI(-1, 1, 4, 15, OP_IMM), 52, 1'b1, 15, 32'hFFFF_FFFA);
        addRow(encI(-2, 2, 2, 16, OP_IMM), 56, 1'b1, 16, 32'd1);
        // x0 write is visible on the port but must not stick
        addRow(encI(7, 1, 0, 0, OP_IMM), 60, 1'b1, 0, 32'd12);
        addRow(encR(0, 1, 0, 0, 17), 64, 1'b1, 17, 32'd5);
        addRow(encS(8, 13, 0), 68, 1'b0, 0, 32'd0);
        addRow(encI(8, 0, 2, 18, OP_LOAD), 72, 1'b1, 18, 32'h1234_5678);
        addRow(encS(12, 12, 0), 76, 1'b0, 0, 32'd0);
        // one ram depth above address 12
        addRow(encI(12 + 4 * RAM_WORDS, 0, 2, 19, OP_LOAD), 80, 1'b1, 19, 32'h1234_5000);
        addRow(encB(8, 17, 1, 0), 84, 1'b0, 0, 32'd0);
        addRow(encB(8, 2, 1, 0), 92, 1'b0, 0, 32'd0);
        addRow(encB(12, 2, 1, 1), 96, 1'b0, 0, 32'd0);
        addRow(encB(8, 17, 1, 1), 108, 1'b0, 0, 32'd0);
        addRow(encB(12, 1, 2, 4), 112, 1'b0, 0, 32'd0);
        addRow(encB(8, 2, 1, 4), 124, 1'b0, 0, 32'd0);
        addRow(encJ(16, 20), 128, 1'b1, 20, 32'd132);
        addRow(encB(-12, 0, 0, 0), 144, 1'b0, 0, 32'd0);
        addRow(encI(1, 0, 0, 21, OP_IMM), 132, 1'b1, 21, 32'd1);
        addRow(encJ(-36, 22), 136, 1'b1, 22, 32'd140);
        addRow(encB(-8, 2, 1, 4), 100, 1'b0, 0, 32'd0);
        addRow(encB(96, 1, 2, 4), 104, 1'b0, 0, 32'd0);
        addRow(encB(-24, 2, 1, 1), 200, 1'b0, 0, 32'd0);
        addRow(32'h0000_0000, 176, 1'b0, 0, 32'd0);
        // clears x5 for the random chain
        addRow(encI(0, 0, 0, 5, OP_IMM), 180, 1'b1, 5, 32'd0);
    endtask

    task automatic checkWord(string name, word_t got, word_t exp);
        if (got !== exp) begin
            $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
            wordErrors++;
        end
    endtask

    task automatic checkIdx(string name, regIdx_t got, regIdx_t exp);
        if (got !== exp) begin
            $display("error at %0t: %s got %0d expected %0d", $time, name, got, exp);
            idxErrors++;
        end
    endtask

    task automatic checkBit(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("error at %0t: %s got %b expected %b", $time, name, got, exp);
            bitErrors++;
        end
    endtask

    task automatic checkRow(word_t pc, logic we, regIdx_t rd, word_t data);
        checkWord("pcAddr_o", pcAddr, pc);
        checkBit("regWe_o", regWe, we);
        if (we) begin
            checkIdx("regAddr_o", regAddr, rd);
            checkWord("regData_o", regData, data);
        end
    endtask

    task automatic finishRun();
        int total;
        total = wordErrors + idxErrors + bitErrors + timeoutErrors;
        $display("errors: word %0d, index %0d, bit %0d, timeout %0d, total %0d",
                 wordErrors, idxErrors, bitErrors, timeoutErrors, total);
        if (total == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    endtask

    initial begin
        logic [11:0] imm;
        word_t       seed;
        word_t       expSum;
        word_t       expPc;
        rstN = 1'b0;
        instr = '0;
        buildTable();
        cycleLimit = instrQ.size() + randomSteps + 20;
        repeat (3) @(posedge clk);
        #1;
        rstN = 1'b1;
        for (int n = 0; n < instrQ.size(); n++) begin
            instr = instrQ[n];
            #3;
            checkRow(pcQ[n], weQ[n], rdQ[n], dataQ[n]);
            @(posedge clk);
            #1;
        end
        // addi x5,x5,imm chain against a running sum
        seed = 32'h465b;
        expSum = '0;
        expPc = pcQ[pcQ.size()-1] + 32'd4;
        for (int n = 0; n < randomSteps; n++) begin
            seed = xorshift(seed);
            imm = seed[11:0];
            expSum = expSum + {{20{imm[11]}}, imm};
            instr = encI({20'b0, imm}, 5, 0, 5, OP_IMM);
            #3;
            checkRow(expPc, 1'b1, 5'd5, expSum);
            expPc = expPc + 32'd4;
            @(posedge clk);
            #1;
        end
        finishRun();
    end

    // watchdog
    initial begin
        wait (cycleLimit != 0);
        while (cycles < cycleLimit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the program did not finish within %0d cycles", cycleLimit);
        timeoutErrors++;
        finishRun();
    end

endmodule

`default_nettype wire

/* project.f */
verilog/cpuPkg.sv
verilog/pcUnit.sv
verilog/controlDecoder.sv
verilog/regFile.sv
verilog/immExtend.sv
verilog/alu.sv
verilog/dataRam.sv
verilog/cpuTop.sv
tb/cpuTop_assert.sv
tb/cpuTop_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the cpuTop testbench with Verilator
set -u
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --assert --top-module cpuTop_tb -f project.f -o cpuTop_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/cpuTop_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "SOME TESTS FAILED" "$LOG"; then
    exit 1
fi
exit 0
